//--- files.f
common/ip_rx_pkg.sv
source/ip_hdr_capture.sv
source/ip_payload_align.sv
source/ip_rx_ctrl.sv
source/ip_rx_top.sv
tb/tb_clock_gen.sv
tb/tb_ip_rx.sv

//--- Makefile
SRCS := $(shell cat files.f)

all: run

obj_dir/Vtb_ip_rx: files.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module tb_ip_rx -f files.f

run: obj_dir/Vtb_ip_rx
	./obj_dir/Vtb_ip_rx > sim.log 2>&1; cat sim.log
	@if grep -q "tests failed" sim.log; then echo "simulation reported failure"; exit 1; fi
	@grep -q "all tests passed" sim.log || (echo "simulation ended without a verdict"; exit 1)

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

//--- tb/tb_ip_rx.sv
/*
 * Testbench for ip_rx_top. Frames are built byte by byte with a valid header checksum.
 * Frames are kept at 25 bytes or more unless a test wants the header cut short.
 */
module tb_ip_rx;

    import ip_rx_pkg::*;

    localparam int TIMEOUT = 2000;

    logic       clk;
    logic       rst;
    data_t      in_tdata;
    keep_t      in_tkeep;
    logic       in_tvalid;
    logic       in_tlast;
    logic       in_tready;
    logic       hdr_valid;
    logic       hdr_ready;
    ip_len_t    ip_length;
    logic [7:0] ip_ttl;
    logic [7:0] ip_protocol;
    ip_addr_t   ip_source_ip;
    ip_addr_t   ip_dest_ip;
    data_t      out_tdata;
    keep_t      out_tkeep;
    logic       out_tvalid;
    logic       out_tlast;
    logic       out_tready;
    logic       busy;
    logic       error_header_early_termination;
    logic       error_invalid_header;
    logic       error_invalid_checksum;
    logic       error_payload_early_termination;

    int seed = 52332;
    int ready_seed = ~52332;
    logic stall_en = 1'b0;
    logic gaps_en = 1'b0;
    logic timed_out = 1'b0;
    logic mid_frame = 1'b0;

    logic [7:0] frame [0:255];
    int frame_len;
    int frame_ip_len;

    // expected results in output order
    logic [95:0] exp_hdr [$];
    logic [7:0]  exp_bytes [$];
    int          exp_len [$];
    logic [95:0] hdr_exp;

    int errors = 0;
    int got_bytes = 0;
    int hdr_seen = 0;
    int frames_seen = 0;
    int cnt_hdr_early = 0;
    int cnt_hdr_bad = 0;
    int cnt_csum = 0;
    int cnt_pay_early = 0;
    int base_cnt [0:5];
    int test_num = 0;
    int tests_ok = 0;
    int test_base_errors = 0;

    tb_clock_gen u_clk (
        .clk (clk),
        .rst (rst)
    );

    ip_rx_top UUT (
        .clk                             (clk),
        .rst                             (rst),
        .in_tdata                        (in_tdata),
        .in_tkeep                        (in_tkeep),
        .in_tvalid                       (in_tvalid),
        .in_tlast                        (in_tlast),
        .in_tready                       (in_tready),
        .hdr_valid                       (hdr_valid),
        .hdr_ready                       (hdr_ready),
        .ip_length                       (ip_length),
        .ip_ttl                          (ip_ttl),
        .ip_protocol                     (ip_protocol),
        .ip_source_ip                    (ip_source_ip),
        .ip_dest_ip                      (ip_dest_ip),
        .out_tdata                       (out_tdata),
        .out_tkeep                       (out_tkeep),
        .out_tvalid                      (out_tvalid),
        .out_tlast                       (out_tlast),
        .out_tready                      (out_tready),
        .busy                            (busy),
        .error_header_early_termination  (error_header_early_termination),
        .error_invalid_header            (error_invalid_header),
        .error_invalid_checksum          (error_invalid_checksum),
        .error_payload_early_termination (error_payload_early_termination)
    );

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected) begin
            $display("FAIL %0t %s got %0h expected %0h", $time, name, got, expected);
            errors++;
        end
    endtask

    // later waits fall through once one has timed out
    task automatic report_timeout(input string what);
        $display("timeout at time %0t: %s", $time, what);
        timed_out = 1'b1;
        errors++;
    endtask

    // standard internet checksum over the 20 header bytes as big-endian words
    function automatic logic [15:0] header_checksum();
        logic [31:0] sum;
        sum = '0;
        for (int k = 0; k < 10; k++) begin
            sum = sum + {16'h0, frame[2*k], frame[2*k+1]};
        end
        while (sum[31:16] != 16'h0) begin
            sum = {16'h0, sum[15:0]} + {16'h0, sum[31:16]};
        end
        return ~sum[15:0];
    endfunction

    // reference header packed as length, ttl, protocol, source and destination
    function automatic logic [95:0] header_fields();
        return {frame[2], frame[3], frame[8], frame[9], frame[12], frame[13], frame[14],
                frame[15], frame[16], frame[17], frame[18], frame[19]};
    endfunction

    // reference payload is cut at the IP length or at the frame end
    function automatic int payload_len_for(input int flen, input int iplen);
        return ((iplen < flen) ? iplen : flen) - 20;
    endfunction

    task automatic build_frame(input int flen, input int iplen, input logic [7:0] ver_ihl);
        frame_len    = flen;
        frame_ip_len = iplen;
        for (int i = 0; i < 256; i++) begin
            frame[i] = 8'($random(seed));
        end
        frame[0]  = ver_ihl;
        frame[1]  = 8'h00;
        frame[2]  = iplen[15:8];
        frame[3]  = iplen[7:0];
        frame[6]  = 8'h40;
        frame[7]  = 8'h00;
        frame[10] = 8'h00;
        frame[11] = 8'h00;
        {frame[10], frame[11]} = header_checksum();
    endtask

    task automatic expect_frame();
        int n;
        n = payload_len_for(frame_len, frame_ip_len);
        exp_hdr.push_back(header_fields());
        for (int i = 0; i < n; i++) begin
            exp_bytes.push_back(frame[20 + i]);
        end
        exp_len.push_back(n);
    endtask

    task automatic send_frame();
        int words;
        int idx;
        int n;
        words = (frame_len + 7) / 8;
        for (int w = 0; w < words; w++) begin
            if (gaps_en && (($random(seed) & 3) == 0)) begin
                in_tvalid = 1'b0;
                @(posedge clk);
                #1;
            end
            for (int i = 0; i < KEEP_W; i++) begin
                idx = w * 8 + i;
                in_tdata[8*i +: 8] = (idx < frame_len) ? frame[idx] : 8'h00;
                in_tkeep[i] = (idx < frame_len);
            end
            in_tvalid = 1'b1;
            in_tlast  = (w == words - 1);
            n = 0;
            @(posedge clk);
            while (!in_tready && !timed_out) begin
                n++;
                if (n > TIMEOUT) begin
                    report_timeout("input word never accepted");
                end else begin
                    @(posedge clk);
                end
            end
            #1;
        end
        in_tvalid = 1'b0;
        in_tlast  = 1'b0;
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        while ((exp_len.size() != 0 || exp_hdr.size() != 0 || busy || hdr_valid
                || out_tvalid) && !timed_out) begin
            n++;
            if (n > TIMEOUT) begin
                report_timeout("frames still pending in the DUT");
            end else begin
                @(posedge clk);
                #1;
            end
        end
        // error pulses land one cycle after their cause
        repeat (2) @(posedge clk);
        #1;
    endtask

    task automatic begin_test();
        test_num++;
        test_base_errors = errors;
        base_cnt[0] = hdr_seen;
        base_cnt[1] = frames_seen;
        base_cnt[2] = cnt_hdr_early;
        base_cnt[3] = cnt_hdr_bad;
        base_cnt[4] = cnt_csum;
        base_cnt[5] = cnt_pay_early;
    endtask

    task automatic check_counts(input int hdrs, input int frames, input int hdr_early,
                                input int hdr_bad, input int csum, input int pay_early);
        check_value("hdr handshakes", 64'(hdr_seen - base_cnt[0]), 64'(hdrs));
        check_value("out_tlast frames", 64'(frames_seen - base_cnt[1]), 64'(frames));
        check_value("error_header_early_termination",
                    64'(cnt_hdr_early - base_cnt[2]), 64'(hdr_early));
        check_value("error_invalid_header", 64'(cnt_hdr_bad - base_cnt[3]), 64'(hdr_bad));
        check_value("error_invalid_checksum", 64'(cnt_csum - base_cnt[4]), 64'(csum));
        check_value("error_payload_early_termination",
                    64'(cnt_pay_early - base_cnt[5]), 64'(pay_early));
    endtask

    task automatic end_test(input string name);
        if (errors == test_base_errors) begin
            tests_ok++;
            $display("test %0d %s: ok", test_num, name);
        end else begin
            $display("test %0d %s: %0d errors", test_num, name, errors - test_base_errors);
        end
    endtask

    // ready lines toggle at random while stalling is on
    initial begin
        out_tready = 1'b0;
        hdr_ready  = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (stall_en) begin
                out_tready = ($random(ready_seed) & 3) != 0;
                hdr_ready  = ($random(ready_seed) & 1) != 0;
            end else begin
                out_tready = 1'b1;
                hdr_ready  = 1'b1;
            end
        end
    end

    // monitor compares header and payload against the expected queues
    always @(posedge clk) begin
        if (!rst) begin
            // a frame still in progress keeps busy high
            if (mid_frame) begin
                check_value("busy", 64'(busy), 64'(1'b1));
            end
            mid_frame = in_tvalid && in_tready && !in_tlast;
            if (hdr_valid && hdr_ready) begin
                hdr_seen++;
                if (exp_hdr.size() == 0) begin
                    $display("unexpected header output at time %0t", $time);
                    errors++;
                end else begin
                    hdr_exp = exp_hdr.pop_front();
                    check_value("ip_length", 64'(ip_length), 64'(hdr_exp[95:80]));
                    check_value("ip_ttl", 64'(ip_ttl), 64'(hdr_exp[79:72]));
                    check_value("ip_protocol", 64'(ip_protocol), 64'(hdr_exp[71:64]));
                    check_value("ip_source_ip", 64'(ip_source_ip), 64'(hdr_exp[63:32]));
                    check_value("ip_dest_ip", 64'(ip_dest_ip), 64'(hdr_exp[31:0]));
                end
            end
            if (out_tvalid && out_tready) begin
                for (int i = 0; i < KEEP_W; i++) begin
                    if (out_tkeep[i] && exp_bytes.size() != 0) begin
                        check_value("out_tdata", 64'(out_tdata[8*i +: 8]),
                                    64'(exp_bytes.pop_front()));
                    end
                    if (out_tkeep[i]) begin
                        got_bytes++;
                    end
                end
                if (exp_len.size() == 0) begin
                    $display("payload word with no frame expected at time %0t", $time);
                    errors++;
                end else if (out_tlast) begin
                    check_value("payload byte count", 64'(got_bytes), 64'(exp_len.pop_front()));
                    got_bytes = 0;
                    frames_seen++;
                end else if (got_bytes >= exp_len[0]) begin
                    $display("out_tlast missing on final payload word at time %0t", $time);
                    errors++;
                end
            end
            if (error_header_early_termination) begin
                cnt_hdr_early++;
            end
            if (error_invalid_header) begin
                cnt_hdr_bad++;
            end
            if (error_invalid_checksum) begin
                cnt_csum++;
            end
            if (error_payload_early_termination) begin
                cnt_pay_early++;
            end
        end
    end

    initial begin
        int n;
        int flen;
        int iplen;
        in_tdata  = '0;
        in_tkeep  = '0;
        in_tvalid = 1'b0;
        in_tlast  = 1'b0;
        n = 0;
        @(posedge clk);
        while (rst && !timed_out) begin
            n++;
            if (n > TIMEOUT) begin
                report_timeout("reset never released");
            end else begin
                @(posedge clk);
            end
        end
        #1;

        begin_test();
        build_frame(57, 57, 8'h45);
        expect_frame();
        send_frame();
        wait_done();
        check_counts(1, 1, 0, 0, 0, 0);
        end_test("single good frame");

        begin_test();
        stall_en = 1'b1;
        gaps_en  = 1'b1;
        for (int k = 0; k < 6; k++) begin
            flen = 25 + (($random(seed) & 32'h7fffffff) % 70);
            build_frame(flen, flen, 8'h45);
            expect_frame();
            send_frame();
        end
        wait_done();
        check_counts(6, 6, 0, 0, 0, 0);
        end_test("back-to-back frames with stalls");

        begin_test();
        gaps_en = 1'b0;
        iplen = 25 + (($random(seed) & 32'h7fffffff) % 40);
        flen  = iplen + 1 + (($random(seed) & 32'h7fffffff) % 20);
        build_frame(flen, iplen, 8'h45);
        expect_frame();
        send_frame();
        build_frame(48, 48, 8'h45);
        expect_frame();
        send_frame();
        wait_done();
        check_counts(2, 2, 0, 0, 0, 0);
        end_test("padded frame trimmed");

        begin_test();
        gaps_en = 1'b1;
        build_frame(60, 60, 8'h45);
        frame[12] = frame[12] ^ 8'h5a;
        send_frame();
        build_frame(60, 60, 8'h65);
        send_frame();
        build_frame(60, 60, 8'h46);
        send_frame();
        build_frame(44, 44, 8'h45);
        expect_frame();
        send_frame();
        wait_done();
        check_counts(1, 1, 0, 2, 1, 0);
        end_test("invalid headers");

        begin_test();
        build_frame(12, 60, 8'h45);
        send_frame();
        build_frame(5, 60, 8'h45);
        send_frame();
        build_frame(40, 60, 8'h45);
        expect_frame();
        send_frame();
        build_frame(33, 33, 8'h45);
        expect_frame();
        send_frame();
        wait_done();
        check_counts(2, 2, 2, 0, 0, 1);
        end_test("early termination");

        $display("summary: %0d run, %0d ok, %0d with errors, %0d check errors",
                 test_num, tests_ok, test_num - tests_ok, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- tb/tb_clock_gen.sv
/*
 * Testbench clock with period 10 and an active high reset held for 3 cycles.
 */
module tb_clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // release just after the third rising edge
    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

//--- source/ip_rx_top.sv
/*
 * IPv4 receiver, 64 bit stream in, header fields and aligned payload out.
 * No IP options, no Ethernet header; out_tready back-pressures the input.
 */
module ip_rx_top
    import ip_rx_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  data_t      in_tdata,
    input  keep_t      in_tkeep,
    input  logic       in_tvalid,
    input  logic       in_tlast,
    output logic       in_tready,
    output logic       hdr_valid,
    input  logic       hdr_ready,
    output ip_len_t    ip_length,
    output logic [7:0] ip_ttl,
    output logic [7:0] ip_protocol,
    output ip_addr_t   ip_source_ip,
    output ip_addr_t   ip_dest_ip,
    output data_t      out_tdata,
    output keep_t      out_tkeep,
    output logic       out_tvalid,
    output logic       out_tlast,
    input  logic       out_tready,
    output logic       busy,
    output logic       error_header_early_termination,
    output logic       error_invalid_header,
    output logic       error_invalid_checksum,
    output logic       error_payload_early_termination
);

    logic  store_word0;
    logic  store_word1;
    logic  store_word2;
    logic  format_ok;
    logic  sum_ok;
    logic  advance;
    logic  load_out;
    keep_t keep_mask;
    logic  force_last;
    logic  flush;
    keep_t shift_tkeep;
    logic  shift_tvalid;
    logic  shift_tlast;

    ip_rx_ctrl u_ctrl (
        .clk                             (clk),
        .rst                             (rst),
        .in_tvalid                       (in_tvalid),
        .in_tlast                        (in_tlast),
        .hdr_ready                       (hdr_ready),
        .ip_length                       (ip_length),
        .format_ok                       (format_ok),
        .sum_ok                          (sum_ok),
        .shift_tkeep                     (shift_tkeep),
        .shift_tvalid                    (shift_tvalid),
        .shift_tlast                     (shift_tlast),
        .out_tvalid                      (out_tvalid),
        .out_tready                      (out_tready),
        .in_tready                       (in_tready),
        .hdr_valid                       (hdr_valid),
        .store_word0                     (store_word0),
        .store_word1                     (store_word1),
        .store_word2                     (store_word2),
        .advance                         (advance),
        .load_out                        (load_out),
        .keep_mask                       (keep_mask),
        .force_last                      (force_last),
        .flush                           (flush),
        .busy                            (busy),
        .error_header_early_termination  (error_header_early_termination),
        .error_invalid_header            (error_invalid_header),
        .error_invalid_checksum          (error_invalid_checksum),
        .error_payload_early_termination (error_payload_early_termination)
    );

    ip_hdr_capture u_hdr (
        .clk          (clk),
        .rst          (rst),
        .in_tdata     (in_tdata),
        .store_word0  (store_word0),
        .store_word1  (store_word1),
        .store_word2  (store_word2),
        .ip_length    (ip_length),
        .ip_ttl       (ip_ttl),
        .ip_protocol  (ip_protocol),
        .ip_source_ip (ip_source_ip),
        .ip_dest_ip   (ip_dest_ip),
        .format_ok    (format_ok),
        .sum_ok       (sum_ok)
    );

    ip_payload_align u_align (
        .clk          (clk),
        .rst          (rst),
        .in_tdata     (in_tdata),
        .in_tkeep     (in_tkeep),
        .in_tvalid    (in_tvalid),
        .in_tlast     (in_tlast),
        .advance      (advance),
        .load_out     (load_out),
        .keep_mask    (keep_mask),
        .force_last   (force_last),
        .flush        (flush),
        .out_tready   (out_tready),
        .shift_tkeep  (shift_tkeep),
        .shift_tvalid (shift_tvalid),
        .shift_tlast  (shift_tlast),
        .out_tdata    (out_tdata),
        .out_tkeep    (out_tkeep),
        .out_tvalid   (out_tvalid),
        .out_tlast    (out_tlast)
    );

endmodule

//--- source/ip_rx_ctrl.sv
/*
 * Frame FSM for the IPv4 receiver. A frame starts with the header in lane 0.
 * Payload is trimmed to ip_length; bytes past it are read and dropped.
 */
module ip_rx_ctrl
    import ip_rx_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    in_tvalid,
    input  logic    in_tlast,
    input  logic    hdr_ready,
    input  ip_len_t ip_length,
    input  logic    format_ok,
    input  logic    sum_ok,
    input  keep_t   shift_tkeep,
    input  logic    shift_tvalid,
    input  logic    shift_tlast,
    input  logic    out_tvalid,
    input  logic    out_tready,
    output logic    in_tready,
    output logic    hdr_valid,
    output logic    store_word0,
    output logic    store_word1,
    output logic    store_word2,
    output logic    advance,
    output logic    load_out,
    output keep_t   keep_mask,
    output logic    force_last,
    output logic    flush,
    output logic    busy,
    output logic    error_header_early_termination,
    output logic    error_invalid_header,
    output logic    error_invalid_checksum,
    output logic    error_payload_early_termination
);

    typedef enum logic [2:0] {S_IDLE, S_HEADER, S_PAYLOAD, S_DRAIN, S_DISCARD} state_t;

    state_t  state;
    state_t  state_next;
    ip_len_t ptr;
    ip_len_t ptr_next;
    ip_len_t ptr_sum;
    ip_len_t pay_len;
    ip_len_t remain;
    logic    in_done;
    logic    idle_rdy;
    logic    in_xfer;
    logic    in_end;
    logic    out_free;
    logic    hdr_last;
    logic    hdr_set;
    logic    err_hdr_early_next;
    logic    err_hdr_next;
    logic    err_csum_next;
    logic    err_pay_early_next;

    assign out_free = !out_tvalid || out_tready;
    assign pay_len  = ip_length - IP_HDR_BYTES;
    assign remain   = pay_len - ptr;
    assign ptr_sum  = ptr + ip_len_t'(keep_to_count(shift_tkeep));
    assign hdr_last = (ptr + ip_len_t'(KEEP_W)) >= IP_HDR_BYTES;

    always_comb begin
        case (state)
            S_IDLE:    in_tready = idle_rdy && !hdr_valid && !out_tvalid;
            S_HEADER:  in_tready = 1'b1;
            S_PAYLOAD: in_tready = out_free && !in_done;
            // trimmed word may still be waiting at the output
            S_DISCARD: in_tready = out_free;
            default:   in_tready = 1'b0;
        endcase
    end

    assign in_xfer = in_tvalid && in_tready;
    assign in_end  = in_done || (in_xfer && in_tlast);

    always_comb begin
        state_next  = state;
        ptr_next    = ptr;
        store_word0 = 1'b0;
        store_word1 = 1'b0;
        store_word2 = 1'b0;
        advance     = 1'b0;
        load_out    = 1'b0;
        keep_mask   = '1;
        force_last  = 1'b0;
        flush       = 1'b0;
        hdr_set     = 1'b0;
        err_hdr_early_next = 1'b0;
        err_hdr_next       = 1'b0;
        err_csum_next      = 1'b0;
        err_pay_early_next = 1'b0;
        case (state)
            S_IDLE: begin
                flush = 1'b1;
                if (in_xfer) begin
                    store_word0 = 1'b1;
                    ptr_next    = ip_len_t'(KEEP_W);
                    if (in_tlast) begin
                        err_hdr_early_next = 1'b1;
                    end else begin
                        state_next = S_HEADER;
                    end
                end
            end
            S_HEADER: begin
                if (in_xfer) begin
                    advance     = 1'b1;
                    store_word1 = !hdr_last;
                    store_word2 = hdr_last;
                    ptr_next    = ptr + ip_len_t'(KEEP_W);
                    if (in_tlast) begin
                        err_hdr_early_next = 1'b1;
                        state_next = S_IDLE;
                    end else if (hdr_last) begin
                        // payload bytes are counted from zero
                        ptr_next = '0;
                        if (!format_ok) begin
                            err_hdr_next = 1'b1;
                            state_next   = S_DISCARD;
                        end else if (!sum_ok) begin
                            err_csum_next = 1'b1;
                            state_next    = S_DISCARD;
                        end else begin
                            hdr_set    = 1'b1;
                            state_next = S_PAYLOAD;
                        end
                    end
                end
            end
            S_PAYLOAD: begin
                if (shift_tvalid && out_free) begin
                    advance  = 1'b1;
                    load_out = 1'b1;
                    ptr_next = ptr_sum;
                    if (ptr_sum >= pay_len) begin
                        keep_mask  = count_to_keep(remain[3:0]);
                        force_last = 1'b1;
                        state_next = (shift_tlast || in_end) ? S_DRAIN : S_DISCARD;
                    end else if (shift_tlast) begin
                        err_pay_early_next = 1'b1;
                        state_next = S_DRAIN;
                    end
                end
            end
            S_DRAIN: begin
                if (out_tvalid && out_tready) begin
                    state_next = S_IDLE;
                end
            end
            S_DISCARD: begin
                if (in_xfer && in_tlast) begin
                    state_next = S_IDLE;
                end
            end
            default: state_next = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= S_IDLE;
            ptr       <= '0;
            in_done   <= 1'b0;
            idle_rdy  <= 1'b0;
            hdr_valid <= 1'b0;
            busy      <= 1'b0;
            error_header_early_termination  <= 1'b0;
            error_invalid_header            <= 1'b0;
            error_invalid_checksum          <= 1'b0;
            error_payload_early_termination <= 1'b0;
        end else begin
            state     <= state_next;
            ptr       <= ptr_next;
            idle_rdy  <= (state_next == S_IDLE);
            hdr_valid <= hdr_set || (hdr_valid && !hdr_ready);
            busy      <= (state_next != S_IDLE);
            if (state == S_IDLE) begin
                in_done <= 1'b0;
            end else if (in_xfer && in_tlast) begin
                in_done <= 1'b1;
            end
            error_header_early_termination  <= err_hdr_early_next;
            error_invalid_header            <= err_hdr_next;
            error_invalid_checksum          <= err_csum_next;
            error_payload_early_termination <= err_pay_early_next;
        end
    end

    // header stays offered with a stable length until taken
    a_hdr_hold: assert property (@(posedge clk) disable iff (rst)
        hdr_valid && !hdr_ready |=> hdr_valid && $stable(ip_length));

endmodule

//--- source/ip_payload_align.sv
/*
 * Shifts the payload down by four lanes so it starts in lane 0.
 * One output register; a new word may only be loaded when it is free.
 */
module ip_payload_align
    import ip_rx_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  data_t in_tdata,
    input  keep_t in_tkeep,
    input  logic  in_tvalid,
    input  logic  in_tlast,
    input  logic  advance,
    input  logic  load_out,
    input  keep_t keep_mask,
    input  logic  force_last,
    input  logic  flush,
    input  logic  out_tready,
    output keep_t shift_tkeep,
    output logic  shift_tvalid,
    output logic  shift_tlast,
    output data_t out_tdata,
    output keep_t out_tkeep,
    output logic  out_tvalid,
    output logic  out_tlast
);

    data_t save_tdata;
    keep_t save_tkeep;
    logic  save_tlast;
    data_t shift_tdata;
    logic  extra;

    // saved last word still has bytes in its upper half
    assign extra = save_tlast && (save_tkeep[KEEP_W-1:HALF_KEEP] != '0);

    always_comb begin
        shift_tdata[HALF_KEEP*8-1:0] = save_tdata[DATA_W-1:HALF_KEEP*8];
        shift_tkeep[HALF_KEEP-1:0]   = save_tkeep[KEEP_W-1:HALF_KEEP];
        if (extra) begin
            shift_tdata[DATA_W-1:HALF_KEEP*8] = '0;
            shift_tkeep[KEEP_W-1:HALF_KEEP]   = '0;
            shift_tvalid = 1'b1;
            shift_tlast  = 1'b1;
        end else begin
            shift_tdata[DATA_W-1:HALF_KEEP*8] = in_tdata[HALF_KEEP*8-1:0];
            shift_tkeep[KEEP_W-1:HALF_KEEP]   = in_tkeep[HALF_KEEP-1:0];
            shift_tvalid = in_tvalid;
            // last only if nothing spills into a flush word
            shift_tlast  = in_tlast && (in_tkeep[KEEP_W-1:HALF_KEEP] == '0);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            save_tkeep <= '0;
            save_tlast <= 1'b0;
        end else if (flush) begin
            save_tkeep <= '0;
            save_tlast <= 1'b0;
        end else if (advance && !extra) begin
            save_tkeep <= in_tkeep;
            save_tlast <= in_tlast;
        end
    end

    always_ff @(posedge clk) begin
        if (advance && !extra && !flush) begin
            save_tdata <= in_tdata;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_tvalid <= 1'b0;
        end else if (load_out) begin
            out_tvalid <= 1'b1;
        end else if (out_tready) begin
            out_tvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load_out) begin
            out_tdata <= shift_tdata;
            out_tkeep <= shift_tkeep & keep_mask;
            out_tlast <= shift_tlast || force_last;
        end
    end

    // the controller must never reload a stalled word
    a_out_hold: assert property (@(posedge clk) disable iff (rst)
        out_tvalid && !out_tready |=>
            out_tvalid && $stable(out_tdata) && $stable(out_tkeep) && $stable(out_tlast));

endmodule

//--- source/ip_hdr_capture.sv
/*
 * Unpacks the big-endian IPv4 header from the first three stream words.
 * sum_ok and format_ok are only meaningful while store_word2 is high.
 */
module ip_hdr_capture
    import ip_rx_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  data_t      in_tdata,
    input  logic       store_word0,
    input  logic       store_word1,
    input  logic       store_word2,
    output ip_len_t    ip_length,
    output logic [7:0] ip_ttl,
    output logic [7:0] ip_protocol,
    output ip_addr_t   ip_source_ip,
    output ip_addr_t   ip_dest_ip,
    output logic       format_ok,
    output logic       sum_ok
);

    logic [3:0]  version;
    logic [3:0]  ihl;
    logic [15:0] sum_a;
    logic [15:0] sum_b;
    logic [15:0] sum_final;

    function automatic logic [17:0] lane_sum(input logic [15:0] a, input logic [15:0] b,
                                             input logic [15:0] c, input logic [15:0] d);
        return 18'(a) + 18'(b) + 18'(c) + 18'(d);
    endfunction

    // end-around carry, two rounds cover any 18 bit sum
    function automatic logic [15:0] fold16(input logic [17:0] s);
        logic [16:0] r;
        r = 17'(s[15:0]) + 17'(s[17:16]);
        return r[15:0] + 16'(r[16]);
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            version <= '0;
            ihl     <= '0;
            sum_a   <= '0;
            sum_b   <= '0;
        end else begin
            if (store_word0) begin
                {version, ihl} <= in_tdata[7:0];
                sum_a <= fold16(lane_sum(in_tdata[15:0], in_tdata[31:16],
                                         in_tdata[47:32], in_tdata[63:48]));
            end
            if (store_word1) begin
                sum_b <= fold16(lane_sum(in_tdata[15:0], in_tdata[31:16],
                                         in_tdata[47:32], in_tdata[63:48]));
            end
        end
    end

    // header fields, byte 0 of each field sits in the lower lane
    always_ff @(posedge clk) begin
        if (store_word0) begin
            ip_length <= {in_tdata[23:16], in_tdata[31:24]};
        end
        if (store_word1) begin
            ip_ttl       <= in_tdata[7:0];
            ip_protocol  <= in_tdata[15:8];
            ip_source_ip <= {in_tdata[39:32], in_tdata[47:40], in_tdata[55:48], in_tdata[63:56]};
        end
        if (store_word2) begin
            ip_dest_ip <= {in_tdata[7:0], in_tdata[15:8], in_tdata[23:16], in_tdata[31:24]};
        end
    end

    // word 2 contributes only its low two lanes
    assign sum_final = fold16(lane_sum(in_tdata[15:0], in_tdata[31:16], sum_a, sum_b));
    assign sum_ok    = (sum_final == CSUM_GOOD);
    assign format_ok = (version == IP_VERSION_V4) && (ihl == IP_IHL_MIN);

endmodule

//--- common/ip_rx_pkg.sv
/*
 * Widths, IPv4 constants and keep helpers shared by the receive path.
 * Keep bits are assumed contiguous from lane 0.
 */
package ip_rx_pkg;

    localparam int DATA_W    = 64;
    localparam int KEEP_W    = 8;
    localparam int HALF_KEEP = 4;

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [KEEP_W-1:0] keep_t;
    typedef logic [15:0]       ip_len_t;
    typedef logic [31:0]       ip_addr_t;

    // only the plain 20 byte header is accepted
    localparam ip_len_t     IP_HDR_BYTES  = 16'd20;
    localparam logic [3:0]  IP_VERSION_V4 = 4'd4;
    localparam logic [3:0]  IP_IHL_MIN    = 4'd5;
    localparam logic [15:0] CSUM_GOOD     = 16'hffff;

    // byte count of a contiguous keep field
    function automatic logic [3:0] keep_to_count(input keep_t keep);
        logic [3:0] n;
        n = '0;
        for (int i = 0; i < KEEP_W; i++) begin
            if (keep[i]) begin
                n = 4'(i + 1);
            end
        end
        return n;
    endfunction

    // count of 0 to 8 bytes back to contiguous keep bits
    function automatic keep_t count_to_keep(input logic [3:0] count);
        keep_t k;
        for (int i = 0; i < KEEP_W; i++) begin
            k[i] = (i < int'(count));
        end
        return k;
    endfunction

endpackage
